//--- Makefile
# Verilator flow for the UART testbench

VERILATOR ?= verilator
FLIST     ?= build.f
TOP       ?= uart_tb
RTL_TOP   ?= uart_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q ">>> PASS" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
common/uart_pkg.sv
logic/baud_gen.sv
logic/sync_fifo.sv
uart/uart_rx.sv
uart/uart_tx.sv
uart/uart_controller.sv
uart/uart_top.sv
tests/uart_checker.sv
tests/uart_tb.sv

//--- common/uart_pkg.sv
package uart_pkg;

    ////////////////////
    // data path sizes
    ////////////////////

    localparam int data_w     = 8;
    // small depth so the full case is easy to reach
    localparam int fifo_depth = 4;
    localparam int fifo_aw    = 2;

    ////////////////////
    // serial timing
    ////////////////////

    // clk cycles per 16x oversampling tick
    localparam int clks_per_tick = 4;
    localparam int ticks_per_bit = 16;
    localparam int div_w         = $clog2(clks_per_tick);
    localparam int tick_w        = $clog2(ticks_per_bit);
    localparam int bit_w         = $clog2(data_w);

    ////////////////////
    // register map
    ////////////////////

    localparam int addr_w = 2;
    localparam logic [addr_w-1:0] reg_data   = 2'd0;
    localparam logic [addr_w-1:0] reg_status = 2'd1;
    localparam logic [addr_w-1:0] reg_irq_en = 2'd2;

    // receiver states
    localparam logic [1:0] rx_st_idle  = 2'd0;
    localparam logic [1:0] rx_st_start = 2'd1;
    localparam logic [1:0] rx_st_data  = 2'd2;
    localparam logic [1:0] rx_st_stop  = 2'd3;

    // transmitter states
    localparam logic [1:0] tx_st_idle  = 2'd0;
    localparam logic [1:0] tx_st_start = 2'd1;
    localparam logic [1:0] tx_st_data  = 2'd2;
    localparam logic [1:0] tx_st_stop  = 2'd3;

    // interrupt machine
    localparam logic irq_st_idle = 1'b0;
    localparam logic irq_st_pend = 1'b1;

    // one read word, seen as a data byte or as status
    typedef union packed {
        logic [data_w-1:0] raw;
        struct packed {
            logic [3:0] rsvd;
            logic       rx_overrun;
            logic       tx_empty;
            logic       tx_full;
            logic       rx_avail;
        } status;
    } uart_rdata_u;

endpackage

//--- logic/baud_gen.sv
`timescale 1ns/1ps

module baud_gen
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    logic [div_w-1:0] div_cnt;

    // free running divider, tick on the wrap cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == div_w'(clks_per_tick - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [data_w-1:0] push_data,
    input  logic              pop,
    output logic [data_w-1:0] pop_data,
    output logic              full,
    output logic              empty
);

    logic [data_w-1:0] mem [fifo_depth];

    // msb is the wrap bit
    logic [fifo_aw:0] wr_ptr;
    logic [fifo_aw:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // same index, different lap -> full
    assign full  = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                   (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // drop illegal requests
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry, no read latency
    assign pop_data = mem[rd_ptr[fifo_aw-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[fifo_aw-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // independent of push, both may happen at once
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- tests/uart_checker.sv
`timescale 1ns/1ps

module uart_checker
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  logic [data_w-1:0] rsp_rdata,
    input  logic              txd,
    input  logic              irq,
    output int                tx_left,
    output int                pass_cnt,
    output int                fail_cnt
);

    localparam int bit_clks = clks_per_tick * ticks_per_bit;

    logic [data_w-1:0] rsp_exp [$];
    logic [data_w-1:0] tx_exp [$];
    logic              rd_pending;
    int                irq_cnt;

    initial begin
        tx_left    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        irq_cnt    = 0;
        rd_pending = 1'b0;
    end

    ////////////////////
    // hooks for the tb
    ////////////////////

    task automatic expect_rsp(input logic [data_w-1:0] val);
        rsp_exp.push_back(val);
    endtask

    task automatic expect_tx(input logic [data_w-1:0] val);
        tx_exp.push_back(val);
        tx_left = tx_left + 1;
    endtask

    task automatic note_pass(input string what);
        pass_cnt = pass_cnt + 1;
        $display("ok   %0t  %s", $time, what);
    endtask

    task automatic note_fail(input string what);
        fail_cnt = fail_cnt + 1;
        $display("fail %0t  %s", $time, what);
    endtask

    task automatic compare(input string sig, input logic [data_w-1:0] exp_v,
                           input logic [data_w-1:0] act_v);
        if (exp_v === act_v) begin
            pass_cnt = pass_cnt + 1;
            $display("ok   %0t  %s = 0x%h", $time, sig, act_v);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("ERROR %0t %s expected 0x%h actual 0x%h", $time, sig, exp_v, act_v);
        end
    endtask

    task automatic check_irq(input int exp_cnt);
        compare("irq_count", exp_cnt[data_w-1:0], irq_cnt[data_w-1:0]);
    endtask

    // read response, sampled away from the clock edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (rd_pending) begin
                if (rsp_valid !== 1'b1) begin
                    note_fail("no read response one cycle after the read");
                end else if (rsp_exp.size() == 0) begin
                    note_fail("read response with nothing expected");
                end else begin
                    compare("rsp_rdata", rsp_exp.pop_front(), rsp_rdata);
                end
            end else if (rsp_valid === 1'b1) begin
                note_fail("read response without a read");
            end
            // the transfer lands on the next rising edge
            rd_pending = req_valid && req_ready && !req_write;
            if (irq === 1'b1) begin
                irq_cnt = irq_cnt + 1;
            end
        end
    end

    ////////////////////
    // txd frame decoder
    ////////////////////

    initial begin : tx_decode
        logic [data_w-1:0] got;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (txd === 1'b0) begin
                // middle of the start bit
                repeat (bit_clks / 2 - 1) @(negedge clk);
                if (txd !== 1'b0) begin
                    note_fail("start bit on txd too short");
                end
                for (int i = 0; i < data_w; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    got[i] = txd;
                end
                repeat (bit_clks) @(negedge clk);
                if (txd !== 1'b1) begin
                    note_fail("stop bit on txd is low");
                end
                if (tx_exp.size() == 0) begin
                    note_fail("frame on txd with no byte written");
                end else begin
                    compare("txd_byte", tx_exp.pop_front(), got);
                    tx_left = tx_left - 1;
                end
            end
        end
    end

endmodule

//--- tests/uart_tb.sv
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    localparam int bit_clks = clks_per_tick * ticks_per_bit;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic              req_write;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_wdata;
    logic              rxd;
    logic              req_ready;
    logic              rsp_valid;
    logic [data_w-1:0] rsp_rdata;
    logic              txd;
    logic              irq;
    int                tx_left;
    int                pass_cnt;
    int                fail_cnt;

    // trace contents
    byte               op_q [$];
    logic [data_w-1:0] arg_q [$];
    logic [data_w-1:0] exp_q [$];
    int                limit_cycles = 0;

    uart_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rxd       (rxd),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .txd       (txd),
        .irq       (irq)
    );

    uart_checker chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .txd       (txd),
        .irq       (irq),
        .tx_left   (tx_left),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // bus and line
    ////////////////////

    // holds the request until req_ready was high before an edge
    task automatic bus_access(input logic wr, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] data, output logic stalled);
        logic rdy;
        stalled = 1'b0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= data;
        do begin
            @(negedge clk);
            rdy = req_ready;
            if (!rdy) stalled = 1'b1;
            @(posedge clk);
        end while (!rdy);
        req_valid <= 1'b0;
        // idle gap between operations
        repeat ($urandom_range(0, 3)) @(posedge clk);
    endtask

    task automatic send_serial(input logic [data_w-1:0] val);
        logic [data_w+1:0] frame;
        frame = {1'b1, val, 1'b0};
        for (int i = 0; i < data_w + 2; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
        // room for the FIFO push and the irq pulse
        repeat (8) @(posedge clk);
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] e;
        fd = $fopen("tests/uart_trace.txt", "r");
        if (fd == 0) begin
            chk.note_fail("trace file tests/uart_trace.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", op, a, e);
                if (n == 3) begin
                    op_q.push_back(op);
                    arg_q.push_back(a[data_w-1:0]);
                    exp_q.push_back(e[data_w-1:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // watchdog sized from the trace length
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("the run timed out before the trace finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        logic        st;
        logic        any_st;
        logic [data_w-1:0] a;
        void'($urandom(32'h1d6));
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        rxd       <= 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        load_trace();
        limit_cycles = (op_q.size() + 1) * 12 * bit_clks + 2000;
        repeat (4) @(posedge clk);
        for (int k = 0; k < op_q.size(); k++) begin
            a = arg_q[k];
            case (op_q[k])
                "W": begin
                    chk.expect_tx(a);
                    bus_access(1'b1, reg_data, a, st);
                end
                "S": begin
                    send_serial(a);
                end
                "R": begin
                    chk.expect_rsp(exp_q[k]);
                    bus_access(1'b0, reg_data, '0, st);
                end
                "T": begin
                    // status is only predictable once txd is quiet
                    while (tx_left != 0) @(posedge clk);
                    chk.expect_rsp(exp_q[k]);
                    bus_access(1'b0, reg_status, '0, st);
                end
                "I": begin
                    chk.check_irq(exp_q[k]);
                    bus_access(1'b1, reg_irq_en, a, st);
                end
                "F": begin
                    any_st = 1'b0;
                    for (int i = 0; i < exp_q[k]; i++) begin
                        chk.expect_tx(a + i[data_w-1:0]);
                        bus_access(1'b1, reg_data, a + i[data_w-1:0], st);
                        any_st = any_st | st;
                    end
                    // depth plus the byte in flight fits without stalling
                    if (exp_q[k] > fifo_depth + 1 && !any_st) begin
                        chk.note_fail("write burst past a full tx FIFO never stalled");
                    end else begin
                        chk.note_pass("write burst finished");
                    end
                end
                default: chk.note_fail("unknown opcode in the trace");
            endcase
        end
        while (tx_left != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tests/uart_trace.txt
# opcode operand expected, hex; W byte, S serial byte, R/T read data/status,
# I irq enable (expected = irq pulses so far), F first byte and burst length
W 41 00
W a5 00
T 00 04
F 10 07
T 00 04
S 3c 00
R 00 3c
R 00 00
T 00 04
S 11 00
S 22 00
S 33 00
S 44 00
S 55 00
T 00 0d
T 00 05
R 00 11
R 00 22
R 00 33
R 00 44
R 00 00
I 01 00
S 5a 00
S 6b 00
R 00 5a
R 00 6b
S 7c 00
R 00 7c
I 00 02
S 99 00
R 00 99
I 00 02

//--- uart/uart_controller.sv
`timescale 1ns/1ps

module uart_controller
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [addr_w-1:0] req_addr,
    input  logic [data_w-1:0] req_wdata,
    input  logic              tx_full,
    input  logic              tx_empty,
    input  logic              rx_empty,
    input  logic [data_w-1:0] rx_data,
    input  logic              rx_done,
    output logic              req_ready,
    output logic              rsp_valid,
    output logic [data_w-1:0] rsp_rdata,
    output logic              tx_push,
    output logic [data_w-1:0] tx_data,
    output logic              rx_pop,
    output logic              irq
);

    logic             xfer;
    logic             rd_xfer;
    logic             data_wr;
    logic             rx_accept;
    logic             irq_en;
    logic             overrun;
    logic             irq_state;
    logic [fifo_aw:0] rx_level;
    uart_rdata_u      rd_word;

    ////////////////////
    // request decode
    ////////////////////

    // stall only a data write into a full tx FIFO
    assign req_ready = !(req_valid && req_write && (req_addr == reg_data) && tx_full);
    assign xfer      = req_valid && req_ready;
    assign rd_xfer   = xfer && !req_write;
    assign data_wr   = xfer && req_write && (req_addr == reg_data);

    assign tx_push = data_wr;
    assign tx_data = req_wdata;

    // empty FIFO -> nothing popped
    assign rx_pop = rd_xfer && (req_addr == reg_data) && !rx_empty;

    // mirror of rx FIFO fill, the FIFO refuses a push when full
    assign rx_accept = rx_done && (rx_level != (fifo_aw + 1)'(fifo_depth));

    // read word
    always_comb begin
        rd_word = '0;
        case (req_addr)
            reg_data: begin
                if (!rx_empty) begin
                    rd_word.raw = rx_data;
                end
            end
            reg_status: begin
                rd_word.status.rx_avail   = !rx_empty;
                rd_word.status.tx_full    = tx_full;
                rd_word.status.tx_empty   = tx_empty;
                rd_word.status.rx_overrun = overrun;
            end
            reg_irq_en: rd_word.raw[0] = irq_en;
            default: rd_word = '0;
        endcase
    end

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            irq_en    <= 1'b0;
            overrun   <= 1'b0;
            rx_level  <= '0;
            irq_state <= irq_st_idle;
            irq       <= 1'b0;
        end else begin
            rsp_valid <= rd_xfer;
            if (xfer && req_write && (req_addr == reg_irq_en)) begin
                irq_en <= req_wdata[0];
            end
            rx_level <= rx_level + rx_accept - rx_pop;
            // status read clears, a new overrun in the same cycle wins
            if (rd_xfer && (req_addr == reg_status)) begin
                overrun <= 1'b0;
            end
            if (rx_done && !rx_accept) begin
                overrun <= 1'b1;
            end
            // one pulse per empty -> non-empty edge
            irq <= 1'b0;
            case (irq_state)
                irq_st_idle: begin
                    if (!rx_empty) begin
                        irq_state <= irq_st_pend;
                        irq       <= irq_en;
                    end
                end
                default: begin
                    if (rx_empty) begin
                        irq_state <= irq_st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_xfer) begin
            rsp_rdata <= rd_word;
        end
    end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tick,
    input  logic              rxd,
    output logic [data_w-1:0] rx_byte,
    output logic              rx_done
);

    // two flop synchronizer plus one stage for edge detect
    logic              rxd_meta;
    logic              rxd_sync;
    logic              rxd_prev;
    logic [1:0]        state;
    logic [tick_w-1:0] tick_cnt;
    logic [bit_w-1:0]  bit_cnt;
    logic [data_w-1:0] shift;
    logic              bit_end;
    logic              sample_bit;

    // 16 ticks into the current bit
    assign bit_end    = tick && (tick_cnt == tick_w'(ticks_per_bit - 1));
    assign sample_bit = (state == rx_st_data) && bit_end;

    assign rx_byte = shift;

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            state    <= rx_st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            rx_done  <= 1'b0;
            case (state)
                rx_st_idle: begin
                    // falling edge on the line
                    if (rxd_prev && !rxd_sync) begin
                        state    <= rx_st_start;
                        tick_cnt <= '0;
                    end
                end
                rx_st_start: begin
                    if (tick) begin
                        if (tick_cnt == tick_w'(ticks_per_bit / 2 - 1)) begin
                            // still low mid bit -> real start bit
                            state    <= rxd_sync ? rx_st_idle : rx_st_data;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                rx_st_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == bit_w'(data_w - 1)) begin
                            state <= rx_st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    // low stop bit is a framing error, byte dropped
                    if (bit_end) begin
                        state   <= rx_st_idle;
                        rx_done <= rxd_sync;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            shift <= {rxd_sync, shift[data_w-1:1]};
        end
    end

endmodule

//--- uart/uart_top.sv
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [addr_w-1:0] req_addr,
    input  logic [data_w-1:0] req_wdata,
    input  logic              rxd,
    output logic              req_ready,
    output logic              rsp_valid,
    output logic [data_w-1:0] rsp_rdata,
    output logic              txd,
    output logic              irq
);

    logic              tick;
    logic              tx_push;
    logic [data_w-1:0] tx_data;
    logic              tx_pop;
    logic [data_w-1:0] tx_head;
    logic              tx_full;
    logic              tx_empty;
    logic [data_w-1:0] rx_byte;
    logic              rx_done;
    logic              rx_pop;
    logic [data_w-1:0] rx_head;
    logic              rx_empty;

    ////////////////////
    // shared time base
    ////////////////////

    baud_gen u_baud_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // core -> line
    sync_fifo tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    // line -> core, full tracked inside the controller
    sync_fifo rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_done),
        .push_data (rx_byte),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (),
        .empty     (rx_empty)
    );

    uart_rx u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .rxd     (rxd),
        .rx_byte (rx_byte),
        .rx_done (rx_done)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_head),
        .fifo_pop   (tx_pop),
        .txd        (txd)
    );

    uart_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .tx_full   (tx_full),
        .tx_empty  (tx_empty),
        .rx_empty  (rx_empty),
        .rx_data   (rx_head),
        .rx_done   (rx_done),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .tx_push   (tx_push),
        .tx_data   (tx_data),
        .rx_pop    (rx_pop),
        .irq       (irq)
    );

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tick,
    input  logic              fifo_empty,
    input  logic [data_w-1:0] fifo_data,
    output logic              fifo_pop,
    output logic              txd
);

    logic [1:0]        state;
    logic [tick_w-1:0] tick_cnt;
    logic [bit_w-1:0]  bit_cnt;
    logic [data_w-1:0] shift;
    logic              bit_end;
    logic              shift_adv;

    assign bit_end = tick && (tick_cnt == tick_w'(ticks_per_bit - 1));

    // take the head byte whenever idle
    assign fifo_pop = (state == tx_st_idle) && !fifo_empty;

    // next data bit goes out at end of start bit and of bits 0..6
    assign shift_adv = bit_end && ((state == tx_st_start) ||
                       ((state == tx_st_data) && (bit_cnt != bit_w'(data_w - 1))));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= tx_st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            if (bit_end) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if (shift_adv) begin
                txd <= shift[0];
            end
            case (state)
                tx_st_idle: begin
                    if (fifo_pop) begin
                        // start bit begins now
                        state    <= tx_st_start;
                        tick_cnt <= '0;
                        txd      <= 1'b0;
                    end
                end
                tx_st_start: begin
                    if (bit_end) begin
                        state   <= tx_st_data;
                        bit_cnt <= '0;
                    end
                end
                tx_st_data: begin
                    if (bit_end) begin
                        if (bit_cnt == bit_w'(data_w - 1)) begin
                            state <= tx_st_stop;
                            txd   <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // back to idle, next pop follows at once
                    if (bit_end) begin
                        state <= tx_st_idle;
                    end
                end
            endcase
        end
    end

    // load on pop, lsb leaves first
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shift <= fifo_data;
        end else if (shift_adv) begin
            shift <= shift >> 1;
        end
    end

endmodule
